/* build.f */
+incdir+.
rv_pkg.sv
alu.sv
immediate_generator.sv
register_file.sv
control_unit.sv
core.sv
core_properties.sv
core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= core_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_TEXT ?= Testbench failed
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else echo "Simulation PASSED"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* core_tb.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module core_tb;
    import rv_pkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic        has_store;
        logic [31:0] store_address;
        logic [31:0] store_data;
    } row_t;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
    } bus_write_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        halt;
    logic        memory_response;
    logic        memory_read;
    logic        memory_write;
    logic [31:0] read_data;
    logic [31:0] address;
    logic [31:0] write_data;

    logic [31:0] mem [256];
    row_t        table_q [$];
    bus_write_t  expected_q [$];
    bus_write_t  observed_q [$];
    logic [31:0] lfsr = 32'hc83a;
    int          countdown = -1;
    int          store_offset = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    bit          table_ready = 1'b0;
    bit          first_read_seen = 1'b0;
    logic        read_before = 1'b0;
    logic        halt_at_edge;

    core core_inst (
        .clk(clk), .reset(reset), .halt(halt), .memory_response(memory_response),
        .read_data(read_data), .memory_read(memory_read), .memory_write(memory_write),
        .address(address), .write_data(write_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd, int op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(int imm20, int rd, int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] next_lfsr(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] word_index(logic [31:0] a);
        return a[9:2];
    endfunction

    function automatic logic [31:0] current_pc();
        return `RV_BOOT_ADDRESS + 32'(table_q.size() * 4);
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr  = next_lfsr(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic add_row(logic [31:0] instr, logic has, logic [31:0] a, logic [31:0] d);
        table_q.push_back({instr, has, a, d});
    endtask

    // Stores to the data area at x1 + offset.
    task automatic add_store(int rs2, logic [31:0] value);
        add_row(enc_s(store_offset, rs2, 1), 1'b1, 32'h200 + 32'(store_offset), value);
        store_offset += 4;
    endtask

    task automatic add_skipped_store(int rs2);
        add_row(enc_s(store_offset, rs2, 1), 1'b0, 32'd0, 32'd0);
        store_offset += 4;
    endtask

    task automatic alu_case(logic [31:0] instr, logic [31:0] expected);
        add_row(instr, 1'b0, 32'd0, 32'd0);
        add_store(5, expected);
    endtask

    // Fall-through marker 0xaa, target marker 0x55.
    task automatic branch_case(int f3, int rs1, int rs2, bit taken);
        add_row(enc_b(8, rs2, rs1, f3), 1'b0, 32'd0, 32'd0);
        if (taken) begin
            add_skipped_store(10);
        end else begin
            add_store(10, 32'haa);
        end
        add_store(9, 32'h55);
    endtask

    task automatic build_program();
        logic [31:0] pc;
        int          off;
        add_row(enc_i(512, 0, 0, 1, OP_IMM), 1'b0, 32'd0, 32'd0); // x1 = data base.
        add_row(enc_i(-7, 0, 0, 2, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_row(enc_i(4, 0, 0, 6, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_row(enc_i(32'h55, 0, 0, 9, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_row(enc_i(32'haa, 0, 0, 10, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_row(enc_u(32'h12345, 3, OP_LUI), 1'b0, 32'd0, 32'd0);
        add_store(3, 32'h1234_5000);
        add_row(enc_i(32'h678, 3, 0, 3, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_store(3, 32'h1234_5678);
        pc = current_pc();
        add_row(enc_u(1, 4, OP_AUIPC), 1'b0, 32'd0, 32'd0);
        add_store(4, pc + 32'h1000);
        // x3 = 0x12345678, x2 = -7, x6 = 4.
        alu_case(enc_r(0, 2, 3, 0, 5, OP_REG), 32'h1234_5678 + 32'hffff_fff9);
        alu_case(enc_r(32, 2, 3, 0, 5, OP_REG), 32'h1234_5678 - 32'hffff_fff9);
        alu_case(enc_r(0, 2, 3, 7, 5, OP_REG), 32'h1234_5678 & 32'hffff_fff9);
        alu_case(enc_r(0, 2, 3, 6, 5, OP_REG), 32'h1234_5678 | 32'hffff_fff9);
        alu_case(enc_r(0, 2, 3, 4, 5, OP_REG), 32'h1234_5678 ^ 32'hffff_fff9);
        alu_case(enc_r(0, 6, 3, 1, 5, OP_REG), 32'h1234_5678 << 4);
        alu_case(enc_r(0, 6, 2, 5, 5, OP_REG), 32'hffff_fff9 >> 4);
        alu_case(enc_r(32, 6, 2, 5, 5, OP_REG), 32'hffff_ffff); // Sign fill.
        alu_case(enc_r(0, 3, 2, 2, 5, OP_REG), 32'd1);
        alu_case(enc_r(0, 3, 2, 3, 5, OP_REG), 32'd0);
        alu_case(enc_i(-8, 3, 0, 5, OP_IMM), 32'h1234_5678 - 32'd8);
        alu_case(enc_i(32'hff, 3, 7, 5, OP_IMM), 32'h0000_0078);
        alu_case(enc_i(32'h10, 2, 6, 5, OP_IMM), 32'hffff_fff9 | 32'h10);
        alu_case(enc_i(-1, 3, 4, 5, OP_IMM), ~32'h1234_5678);
        alu_case(enc_i(8, 3, 1, 5, OP_IMM), 32'h1234_5678 << 8);
        alu_case(enc_i(28, 2, 5, 5, OP_IMM), 32'h0000_000f);
        alu_case(enc_i(32'h401, 2, 5, 5, OP_IMM), 32'hffff_fffc);
        alu_case(enc_i(0, 2, 2, 5, OP_IMM), 32'd1);
        alu_case(enc_i(5, 2, 3, 5, OP_IMM), 32'd0);
        off = store_offset;
        add_store(3, 32'h1234_5678);
        add_row(enc_i(off, 1, 2, 7, OP_LOAD), 1'b0, 32'd0, 32'd0);
        add_store(7, 32'h1234_5678);
        branch_case(0, 3, 3, 1'b1);
        branch_case(0, 3, 2, 1'b0);
        branch_case(1, 3, 2, 1'b1);
        branch_case(1, 3, 3, 1'b0);
        branch_case(4, 2, 3, 1'b1);
        branch_case(4, 3, 2, 1'b0);
        branch_case(5, 3, 2, 1'b1);
        branch_case(5, 2, 3, 1'b0);
        pc = current_pc();
        add_row(enc_j(8, 11), 1'b0, 32'd0, 32'd0);
        add_skipped_store(10);
        add_store(11, pc + 32'd4);
        pc = current_pc();
        add_row(enc_u(0, 12, OP_AUIPC), 1'b0, 32'd0, 32'd0);
        add_row(enc_i(13, 12, 0, 13, OP_JALR), 1'b0, 32'd0, 32'd0); // Bit 0 cleared.
        add_skipped_store(10);
        add_store(13, pc + 32'd8);
        add_row(enc_i(123, 0, 0, 0, OP_IMM), 1'b0, 32'd0, 32'd0);
        add_store(0, 32'd0);
        add_row(enc_j(0, 0), 1'b0, 32'd0, 32'd0); // Spin here.
    endtask

    // Memory answers each strobe after 0 to 3 cycles.
    always @(posedge clk) begin
        #1;
        memory_response = 1'b0;
        if (reset) begin
            countdown = -1;
        end else if (memory_read || memory_write) begin
            if (countdown < 0) begin
                take_bits(2, countdown);
            end
            if (countdown == 0) begin
                if (memory_write) begin
                    mem[word_index(address)] = write_data;
                    observed_q.push_back({address, write_data});
                end else begin
                    read_data = mem[word_index(address)];
                end
                memory_response = 1'b1;
                countdown = -1;
            end else begin
                countdown--;
            end
        end
    end

    always @(posedge clk) begin
        halt_at_edge = halt;
        #5;
        if (reset) begin
            assert (!memory_read && !memory_write) else begin
                $display("Bus strobe active during reset at %0t", $time);
                failure_count++;
            end
        end else begin
            if (!first_read_seen) begin
                assert (!memory_write) else begin
                    $display("Write issued before the first fetch at %0t", $time);
                    failure_count++;
                end
                if (memory_read) begin
                    first_read_seen = 1'b1;
                    assert (address == `RV_BOOT_ADDRESS) else begin
                        $display("MISMATCH time=%0t signal=address expected=%h actual=%h",
                                 $time, `RV_BOOT_ADDRESS, address);
                        mismatch_count++;
                    end
                end
            end
            if (memory_read && !read_before && address < 32'h200) begin
                assert (!halt_at_edge) else begin
                    $display("Fetch started while halt was high at %0t", $time);
                    failure_count++;
                end
            end
        end
        read_before = memory_read;
    end

    task automatic check_stores();
        int n;
        assert (observed_q.size() == expected_q.size()) else begin
            $display("Saw %0d stores where %0d were expected",
                     observed_q.size(), expected_q.size());
            failure_count++;
        end
        n = (observed_q.size() < expected_q.size()) ? observed_q.size() : expected_q.size();
        for (int i = 0; i < n; i++) begin
            assert (observed_q[i].address == expected_q[i].address) else begin
                $display("MISMATCH time=%0t signal=address expected=%h actual=%h (store %0d)",
                         $time, expected_q[i].address, observed_q[i].address, i);
                mismatch_count++;
            end
            assert (observed_q[i].data == expected_q[i].data) else begin
                $display("MISMATCH time=%0t signal=write_data expected=%h actual=%h (store %0d)",
                         $time, expected_q[i].data, observed_q[i].data, i);
                mismatch_count++;
            end
        end
    endtask

    initial begin
        logic [31:0] spin_pc;
        reset           = 1'b1;
        halt            = 1'b0;
        memory_response = 1'b0;
        read_data       = 32'd0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i * 4) ^ 32'hdead_beef;
        end
        build_program();
        spin_pc = current_pc() - 32'd4;
        foreach (table_q[i]) begin
            mem[word_index(`RV_BOOT_ADDRESS + 32'(i * 4))] = table_q[i].instr;
            if (table_q[i].has_store) begin
                expected_q.push_back({table_q[i].store_address, table_q[i].store_data});
            end
        end
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        repeat (30) @(posedge clk);
        #1 halt = 1'b1; // Core must stall in fetch.
        repeat (25) @(posedge clk);
        #1 halt = 1'b0;
        // The program is done once the closing jump fetches itself.
        while (!(memory_read && address == spin_pc)) begin
            @(posedge clk);
            #5;
        end
        check_stores();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        int limit;
        while (!table_ready) begin
            @(posedge clk);
        end
        limit = table_q.size() * `RV_TIMEOUT_SCALE;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 limit, observed_q.size(), expected_q.size());
        $display("Testbench failed");
        $finish;
    end

endmodule

/* core_properties.sv */
`timescale 1ns/1ps

module core_properties (
    input logic        clk,
    input logic        reset,
    input logic        memory_read,
    input logic        memory_write,
    input logic        memory_response,
    input logic [31:0] address,
    input logic [31:0] write_data
);

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(memory_read && memory_write))
        else $error("Read and write strobes are high together");

    // A pending strobe holds its request until the response.
    read_held: assert property (@(posedge clk) disable iff (reset)
        memory_read && !memory_response |=> memory_read && $stable(address))
        else $error("Read request changed before its response");

    write_held: assert property (@(posedge clk) disable iff (reset)
        memory_write && !memory_response |=>
            memory_write && $stable(address) && $stable(write_data))
        else $error("Write request changed before its response");

    word_aligned: assert property (@(posedge clk) disable iff (reset)
        (memory_read || memory_write) |-> address[1:0] == 2'b00)
        else $error("Bus address is not word aligned");

endmodule

bind core core_properties core_properties_inst (
    .clk(clk), .reset(reset), .memory_read(memory_read), .memory_write(memory_write),
    .memory_response(memory_response), .address(address), .write_data(write_data)
);

/* core.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module core (
    input  logic        clk,
    input  logic        reset,
    input  logic        halt,
    input  logic        memory_response,
    input  logic [31:0] read_data,
    output logic        memory_read,
    output logic        memory_write,
    output logic [31:0] address,
    output logic [31:0] write_data
);
    import rv_pkg::*;

    ctrl_t       ctrl;
    instr_t      ir;
    logic        branch_taken;
    logic        pc_load;
    logic [31:0] pc;
    logic [31:0] old_pc;
    logic [31:0] mdr;
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [31:0] alu_result_q;
    logic [31:0] rf_data_1;
    logic [31:0] rf_data_2;
    logic [31:0] immediate;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic [31:0] wb_data;
    logic [31:0] pc_next;

    control_unit control_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .halt            (halt),
        .memory_response (memory_response),
        .instr           (ir),
        .branch_taken    (branch_taken),
        .ctrl            (ctrl),
        .memory_read     (memory_read),
        .memory_write    (memory_write)
    );

    register_file register_file_inst (
        .clk          (clk),
        .reset        (reset),
        .write_enable (ctrl.reg_write),
        .read_index_1 (ir.r.rs1),
        .read_index_2 (ir.r.rs2),
        .write_index  (ir.r.rd),
        .write_data   (wb_data),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2)
    );

    immediate_generator immediate_generator_inst (
        .instr     (ir),
        .immediate (immediate)
    );

    alu alu_inst (
        .op           (ctrl.alu_op),
        .operand_a    (alu_a),
        .operand_b    (alu_b),
        .result       (alu_out),
        .branch_taken (branch_taken)
    );

    always_comb begin
        case (ctrl.alu_src_a)
            SRC_A_PC:     alu_a = pc;
            SRC_A_OLD_PC: alu_a = old_pc;
            SRC_A_RS1:    alu_a = rs1_q;
            default:      alu_a = 32'd0;
        endcase
        case (ctrl.alu_src_b)
            SRC_B_RS2:  alu_b = rs2_q;
            SRC_B_FOUR: alu_b = 32'd4;
            default:    alu_b = immediate;
        endcase
    end

    assign address    = (ctrl.address_sel == ADDR_PC) ? pc : alu_result_q;
    assign write_data = rs2_q;
    assign wb_data    = (ctrl.wb_sel == WB_MEMORY) ? mdr : alu_result_q;
    assign pc_next    = (ctrl.pc_source == PC_SRC_ALU) ? alu_out : alu_result_q;
    assign pc_load    = ctrl.pc_write | (ctrl.pc_write_cond & branch_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_BOOT_ADDRESS;
        end else if (pc_load) begin
            pc <= {pc_next[31:1], 1'b0}; // JALR clears bit 0.
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir     <= instr_t'(read_data);
            old_pc <= pc;
        end
        if (memory_response) begin
            mdr <= read_data;
        end
        rs1_q        <= rf_data_1;
        rs2_q        <= rf_data_2;
        alu_result_q <= alu_out;
    end

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           halt,
    input  logic           memory_response,
    input  rv_pkg::instr_t instr,
    input  logic           branch_taken,
    output rv_pkg::ctrl_t  ctrl,
    output logic           memory_read,
    output logic           memory_write
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK
    } state_t;

    state_t  state;
    opcode_t opcode;
    alu_op_t funct_op;
    alu_op_t branch_op;

    assign opcode = opcode_t'(instr.r.opcode);

    // ALU operation for register and immediate arithmetic.
    always_comb begin
        case (instr.r.funct3)
            3'b000:  funct_op = (opcode == OP_REG && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
        case (instr.r.funct3)
            3'b000:  branch_op = ALU_EQ;
            3'b001:  branch_op = ALU_NE;
            3'b100:  branch_op = ALU_LT;
            3'b101:  branch_op = ALU_GE;
            default: branch_op = ALU_ADD; // Flag stays low.
        endcase
    end

    always_comb begin
        ctrl.pc_write      = 1'b0;
        ctrl.pc_write_cond = 1'b0;
        ctrl.ir_write      = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.address_sel   = ADDR_PC;
        ctrl.alu_src_a     = SRC_A_PC;
        ctrl.alu_src_b     = SRC_B_FOUR;
        ctrl.wb_sel        = WB_RESULT;
        ctrl.pc_source     = PC_SRC_ALU;
        ctrl.alu_op        = ALU_ADD;
        case (state)
            S_FETCH: begin
                // PC + 4 lands together with the instruction.
                ctrl.ir_write = memory_read && memory_response;
                ctrl.pc_write = memory_read && memory_response;
            end
            S_DECODE: begin
                // Branch target, or link value for jumps.
                ctrl.alu_src_a = SRC_A_OLD_PC;
                if (opcode != OP_JAL && opcode != OP_JALR) begin
                    ctrl.alu_src_b = SRC_B_IMM;
                end
            end
            S_EXECUTE: begin
                ctrl.alu_src_a = SRC_A_RS1;
                ctrl.alu_src_b = SRC_B_IMM;
                case (opcode)
                    OP_REG: begin
                        ctrl.alu_src_b = SRC_B_RS2;
                        ctrl.alu_op    = funct_op;
                    end
                    OP_IMM:   ctrl.alu_op = funct_op;
                    OP_LUI:   ctrl.alu_src_a = SRC_A_ZERO;
                    OP_AUIPC: ctrl.alu_src_a = SRC_A_OLD_PC;
                    OP_BRANCH: begin
                        ctrl.alu_src_b     = SRC_B_RS2;
                        ctrl.alu_op        = branch_op;
                        ctrl.pc_write_cond = branch_taken;
                        ctrl.pc_source     = PC_SRC_RESULT;
                    end
                    OP_JAL: begin
                        ctrl.alu_src_a = SRC_A_OLD_PC;
                        ctrl.pc_write  = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    OP_JALR: begin
                        ctrl.pc_write  = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            S_MEMORY: begin
                // Keep the address computation alive while waiting.
                ctrl.address_sel = ADDR_RESULT;
                ctrl.alu_src_a   = SRC_A_RS1;
                ctrl.alu_src_b   = SRC_B_IMM;
            end
            S_WRITEBACK: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = (opcode == OP_LOAD) ? WB_MEMORY : WB_RESULT;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_FETCH;
            memory_read  <= 1'b0;
            memory_write <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (memory_read) begin
                        if (memory_response) begin
                            memory_read <= 1'b0;
                            state       <= S_DECODE;
                        end
                    end else if (!halt) begin
                        memory_read <= 1'b1;
                    end
                end
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE: begin
                    case (opcode)
                        OP_LOAD: begin
                            memory_read <= 1'b1;
                            state       <= S_MEMORY;
                        end
                        OP_STORE: begin
                            memory_write <= 1'b1;
                            state        <= S_MEMORY;
                        end
                        OP_REG, OP_IMM, OP_LUI, OP_AUIPC: state <= S_WRITEBACK;
                        default: state <= S_FETCH;
                    endcase
                end
                S_MEMORY: begin
                    if (memory_response) begin
                        memory_read  <= 1'b0;
                        memory_write <= 1'b0;
                        state        <= (opcode == OP_LOAD) ? S_WRITEBACK : S_FETCH;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_enable,
    input  logic [4:0]  read_index_1,
    input  logic [4:0]  read_index_2,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_1,
    output logic [31:0] read_data_2
);

    logic [31:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // x0 is hardwired.
    assign read_data_1 = (read_index_1 == 5'd0) ? 32'd0 : regs[read_index_1];
    assign read_data_2 = (read_index_2 == 5'd0) ? 32'd0 : regs[read_index_2];

endmodule

/* immediate_generator.sv */
`timescale 1ns/1ps

module immediate_generator (
    input  rv_pkg::instr_t instr,
    output logic [31:0]    immediate
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr.r.funct7[6];

    always_comb begin
        case (opcode_t'(instr.r.opcode))
            OP_STORE: begin
                immediate = {{20{sign}}, instr.r.funct7, instr.r.rd};
            end
            OP_BRANCH: begin
                immediate = {{20{sign}}, instr.r.rd[0], instr.r.funct7[5:0],
                             instr.r.rd[4:1], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                immediate = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'd0};
            end
            OP_JAL: begin
                // Bits 19:12 sit where rs1 and funct3 are.
                immediate = {{12{sign}}, instr.i.rs1, instr.i.funct3,
                             instr.i.imm12[0], instr.i.imm12[10:1], 1'b0};
            end
            default: begin
                immediate = {{20{sign}}, instr.i.imm12}; // I format.
            end
        endcase
    end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_t op,
    input  logic [31:0]     operand_a,
    input  logic [31:0]     operand_b,
    output logic [31:0]     result,
    output logic            branch_taken
);
    import rv_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] diff;
    logic        equal;
    logic        less_signed;
    logic        less_unsigned;

    assign shamt         = operand_b[4:0];
    assign diff          = operand_a - operand_b;
    assign equal         = (operand_a == operand_b);
    assign less_signed   = ($signed(operand_a) < $signed(operand_b));
    assign less_unsigned = (operand_a < operand_b);

    always_comb begin
        case (op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_AND:  result = operand_a & operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_SLL:  result = operand_a << shamt;
            ALU_SRL:  result = operand_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
            ALU_SLT:  result = {31'd0, less_signed};
            ALU_SLTU: result = {31'd0, less_unsigned};
            default:  result = diff; // SUB and the compares.
        endcase
    end

    always_comb begin
        case (op)
            ALU_EQ:  branch_taken = equal;
            ALU_NE:  branch_taken = !equal;
            ALU_LT:  branch_taken = less_signed;
            ALU_GE:  branch_taken = !less_signed;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // Register form view of an instruction word.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // Immediate form view of the same word.
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // Compare ops drive the branch flag; their result is a - b.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE
    } alu_op_t;

    typedef enum logic {ADDR_PC, ADDR_RESULT} addr_sel_t;
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1, SRC_A_ZERO} src_a_t;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_FOUR, SRC_B_IMM} src_b_t;
    typedef enum logic {WB_RESULT, WB_MEMORY} wb_sel_t;
    typedef enum logic {PC_SRC_ALU, PC_SRC_RESULT} pc_src_t;

    typedef struct packed {
        logic      pc_write;
        logic      pc_write_cond;
        logic      ir_write;
        logic      reg_write;
        addr_sel_t address_sel;
        src_a_t    alu_src_a;
        src_b_t    alu_src_b;
        wb_sel_t   wb_sel;
        pc_src_t   pc_source;
        alu_op_t   alu_op;
    } ctrl_t;

endpackage

/* rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Reset value of the program counter.
`define RV_BOOT_ADDRESS 32'h0000_0000

// Architectural integer registers.
`define RV_REG_COUNT 32

// Watchdog cycles per program row for 20 instructions of up to 8 cycles.
`define RV_TIMEOUT_SCALE (20 * 8)

`endif
